// ==== cnn_vectors.txt ====
// one 16-bit hex word per line
// @00 pixels row-major, @24 weights row-major, @2d bias, @30 expected results
@00
fc18
0001
0002
0003
0004
0005
0006
0007
0008
0009
000a
000b
000c
000d
000e
000f
0010
0011
0012
0013
0014
0015
0016
0017
0018
0019
001a
001b
001c
001d
001e
001f
0020
0021
0022
7fff
@24
0001
0002
0001
0000
0001
0000
ffff
0000
0001
@2d
0005
@30
0000
0017
001c
0021
0030
0035
003a
003f
004e
0053
0058
005d
006c
0071
0076
7fff

// ==== tb.f ====
+incdir+.
cnn_pkg.sv
local_read_if.sv
bus_write_decoder.sv
local_store.sv
conv_layer.sv
result_store.sv
top.sv
tb_clock_gen.sv
tb_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_top -f tb.f -o Vtb_top
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
	exit 0
else
	exit 1
fi

// ==== tb_top.sv ====
`include "cnn_config.svh"
`timescale 1ns/10ps

module tb_top import cnn_pkg::*; ();

	localparam int PIX_OFF   = 'h00;
	localparam int KER_OFF   = 'h24;
	localparam int BIAS_OFF  = 'h2d;
	localparam int EXP_OFF   = 'h30;
	localparam int IRQ_LIMIT = 2000;

	logic      clk;
	logic      rst;
	bus_word_t araddr;
	logic      arvalid;
	bus_word_t wdata;
	logic      wvalid;
	bus_word_t awaddr;
	logic      awvalid;
	bus_word_t rdata;
	logic      interrupt_signal;

	logic [15:0] vec_mem [64];
	pixel_t      pixels [`PIX_COUNT];
	weight_t     weights [`KER_COUNT];
	bias_t       bias;
	result_t     expected [`OUT_COUNT];
	int          errors;
	bit          seen;
	bus_word_t   word;

	tb_clock_gen clock_gen (
		.clk(clk)
	);

	top top_inst (
		.clk(clk),
		.rst(rst),
		.araddr(araddr),
		.arvalid(arvalid),
		.wdata(wdata),
		.wvalid(wvalid),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.rdata(rdata),
		.interrupt_signal(interrupt_signal)
	);

	task automatic check_result(input string what, input result_t got, input result_t exp);
		if (got !== exp)
		begin
			$display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_status(input string what, input bus_word_t got, input bus_word_t exp);
		if (got !== exp)
		begin
			$display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_interrupt(input string what, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("[FAIL] %0t: %s interrupt_signal %b expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	// unfilled entries keep the marker word
	task automatic load_vectors();
		int missing;
		missing = 0;
		for (int k = 0; k < 64; k++)
			vec_mem[k] = 16'hdead;
		$readmemh("cnn_vectors.txt", vec_mem);
		for (int k = 0; k < `PIX_COUNT; k++)
		begin
			pixels[k] = pixel_t'(vec_mem[PIX_OFF + k]);
			if (vec_mem[PIX_OFF + k] == 16'hdead)
				missing++;
		end
		for (int k = 0; k < `KER_COUNT; k++)
		begin
			weights[k] = weight_t'(vec_mem[KER_OFF + k]);
			if (vec_mem[KER_OFF + k] == 16'hdead)
				missing++;
		end
		bias = bias_t'(vec_mem[BIAS_OFF]);
		if (vec_mem[BIAS_OFF] == 16'hdead)
			missing++;
		for (int k = 0; k < `OUT_COUNT; k++)
		begin
			expected[k] = result_t'(vec_mem[EXP_OFF + k]);
			if (vec_mem[EXP_OFF + k] == 16'hdead)
				missing++;
		end
		if (missing != 0)
		begin
			$display("vectors file is missing %0d entries", missing);
			errors++;
		end
	endtask

	task automatic bus_write(input bus_word_t addr, input bus_word_t data);
		@(posedge clk);
		awaddr  <= addr;
		wdata   <= data;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		repeat ($urandom % 4) @(posedge clk);
	endtask

	// rdata is registered on the edge after arvalid
	task automatic bus_read(input bus_word_t addr, output bus_word_t data);
		@(posedge clk);
		araddr  <= addr;
		arvalid <= 1'b1;
		@(posedge clk);
		arvalid <= 1'b0;
		@(negedge clk);
		data = rdata;
	endtask

	task automatic wait_interrupt(input int limit, output bit raised);
		int cycles;
		raised = 1'b0;
		cycles = 0;
		while (!raised && cycles < limit)
		begin
			@(negedge clk);
			raised = interrupt_signal;
			cycles++;
		end
	endtask

	task automatic write_pixels();
		for (int k = 0; k < `PIX_COUNT; k++)
			bus_write(`PIXEL_BASE + bus_word_t'(k * 4), {16'h0000, pixels[k]});
	endtask

	task automatic write_weights();
		for (int k = 0; k < `KER_COUNT; k++)
			bus_write(`WEIGHT_BASE + bus_word_t'(k * 4), {16'h0000, weights[k]});
	endtask

	task automatic run_and_check(input string tag);
		bit        raised;
		bus_word_t value;
		bus_write(`START_ADDR, 32'h1);
		wait_interrupt(IRQ_LIMIT, raised);
		if (!raised)
		begin
			$display("timeout waiting for interrupt_signal in %s", tag);
			errors++;
		end
		for (int k = 0; k < `OUT_COUNT; k++)
		begin
			bus_read(`RESULT_BASE + bus_word_t'(k * 4), value);
			check_result($sformatf("%s result %0d", tag, k), result_t'(value[15:0]), expected[k]);
			check_status($sformatf("%s result %0d upper half", tag, k), value & 32'hffff_0000, '0);
		end
	endtask

	initial
	begin
		errors  = 0;
		rst     = 1'b1;
		araddr  = '0;
		arvalid = 1'b0;
		wdata   = '0;
		wvalid  = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		void'($urandom(32'h34c9));
		load_vectors();
		repeat (16) @(posedge clk);
		rst <= 1'b0;

		@(negedge clk);
		check_interrupt("after reset", interrupt_signal, 1'b0);
		bus_read(`STATUS_ADDR, word);
		check_status("status after reset", word, 32'h0);

		// weights missing, start must be dropped
		bus_write(`BIAS_ADDR, {16'h0000, bias});
		write_pixels();
		bus_read(`STATUS_ADDR, word);
		check_status("status without weights", word, 32'h5);
		bus_write(`START_ADDR, 32'h1);
		wait_interrupt(IRQ_LIMIT, seen);
		if (seen)
		begin
			$display("interrupt raised before the weights were loaded");
			errors++;
		end
		bus_read(`STATUS_ADDR, word);
		check_status("status after ignored start", word, 32'h5);

		write_weights();
		bus_read(`STATUS_ADDR, word);
		check_status("status with all stores", word, 32'h7);
		run_and_check("first run");
		bus_read(`STATUS_ADDR, word);
		check_status("status after first run", word, 32'h17);

		bus_write(`IRQ_CLEAR_ADDR, 32'h0);
		@(negedge clk);
		check_interrupt("after clear", interrupt_signal, 1'b0);
		bus_read(`STATUS_ADDR, word);
		check_status("status after clear", word, 32'h7);

		run_and_check("second run");
		bus_read(32'h7000_0000, word);
		check_status("unmapped read", word, 32'h0);
		bus_read(32'hd000_2000, word);
		check_status("unmapped read near status", word, 32'h0);

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter real PERIOD = 4.0
)
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2.0) clk = ~clk;
	end

endmodule

// ==== top.sv ====
`timescale 1ns/10ps

module top import cnn_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  bus_word_t araddr,
	input  logic      arvalid,
	input  bus_word_t wdata,
	input  logic      wvalid,
	input  bus_word_t awaddr,
	input  logic      awvalid,
	output bus_word_t rdata,
	output logic      interrupt_signal
);

	logic       write_signal;
	logic [1:0] write_target;
	pix_idx_t   write_index;
	pixel_t     write_data;
	logic       start;
	logic       irq_clear;
	logic       pixel_done;
	logic       weight_done;
	logic       bias_done;
	logic       busy;
	logic       save_enable;
	out_idx_t   save_index;
	result_t    save_data;
	logic       calc_done;

	local_read_if rd_bus();

	// input side
	bus_write_decoder decoder(
		.clk(clk),
		.rst(rst),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.wdata(wdata),
		.wvalid(wvalid),
		.write_signal(write_signal),
		.write_target(write_target),
		.write_index(write_index),
		.write_data(write_data),
		.start(start),
		.irq_clear(irq_clear),
		.pixel_done(pixel_done),
		.weight_done(weight_done),
		.bias_done(bias_done),
		.busy(busy)
	);

	local_store store(
		.clk(clk),
		.rst(rst),
		.write_signal(write_signal),
		.write_target(write_target),
		.write_index(write_index),
		.write_data(write_data),
		.rd(rd_bus.store)
	);

	conv_layer layer(
		.clk(clk),
		.rst(rst),
		.start(start),
		.rd(rd_bus.layer),
		.save_enable(save_enable),
		.save_index(save_index),
		.save_data(save_data),
		.calc_done(calc_done),
		.busy(busy)
	);

	// output side
	result_store result(
		.clk(clk),
		.rst(rst),
		.save_enable(save_enable),
		.save_index(save_index),
		.save_data(save_data),
		.calc_done(calc_done),
		.irq_clear(irq_clear),
		.pixel_done(pixel_done),
		.weight_done(weight_done),
		.bias_done(bias_done),
		.busy(busy),
		.araddr(araddr),
		.arvalid(arvalid),
		.rdata(rdata),
		.interrupt_signal(interrupt_signal)
	);

endmodule

// ==== result_store.sv ====
`include "cnn_config.svh"
`timescale 1ns/10ps

module result_store import cnn_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      save_enable,
	input  out_idx_t  save_index,
	input  result_t   save_data,
	input  logic      calc_done,
	input  logic      irq_clear,
	input  logic      pixel_done,
	input  logic      weight_done,
	input  logic      bias_done,
	input  logic      busy,
	input  bus_word_t araddr,
	input  logic      arvalid,
	output bus_word_t rdata,
	output logic      interrupt_signal
);

	result_t   result_mem [`OUT_COUNT];
	bus_word_t read_word;

	always_ff @(posedge clk)
	begin
		if (save_enable)
			result_mem[save_index] <= save_data;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			interrupt_signal <= 1'b0;
		else if (calc_done)
			interrupt_signal <= 1'b1;
		else if (irq_clear)
			interrupt_signal <= 1'b0;
	end

	// result window, status word, zero elsewhere
	always_comb
	begin
		if ((araddr & `RD_RESULT_MASK) == `RESULT_BASE)
			read_word = {{(`BUS_W - `DATA_W){1'b0}}, result_mem[araddr[5:2]]};
		else if (araddr == `STATUS_ADDR)
			read_word = {27'd0, interrupt_signal, busy, bias_done, weight_done, pixel_done};
		else
			read_word = '0;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			rdata <= '0;
		else if (arvalid)
			rdata <= read_word;
	end

	a_done_vs_clear: assert property (@(posedge clk) disable iff (rst)
		!(calc_done && irq_clear));

endmodule

// ==== conv_layer.sv ====
`include "cnn_config.svh"
`timescale 1ns/10ps

module conv_layer import cnn_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        start,
	local_read_if.layer rd,
	output logic        save_enable,
	output out_idx_t    save_index,
	output result_t     save_data,
	output logic        calc_done,
	output logic        busy
);

	conv_state_t state;
	logic [2:0]  out_row;
	logic [2:0]  out_col;
	logic [1:0]  ker_row;
	logic [1:0]  ker_col;
	ker_idx_t    ker_cnt;
	logic        acc_valid;
	acc_t        acc;
	acc_t        product;
	acc_t        final_sum;

	function automatic result_t relu_sat(input acc_t sum);
		if (sum < 0)
			return '0;
		else if (sum > `SAT_MAX)
			return result_t'(`SAT_MAX);
		else
			return result_t'(sum);
	endfunction

	// one tap per cycle while fetching
	assign rd.read_signal = (state == FETCH);
	assign rd.ker_addr    = ker_cnt;
	assign rd.pix_addr    = pix_idx_t'((out_row + ker_row) * `IMG_DIM + out_col + ker_col);

	assign product   = acc_t'(rd.pixel_data) * acc_t'(rd.weight_data);
	assign final_sum = acc + product + acc_t'(rd.bias_data);
	assign calc_done = (state == DONE);
	assign busy      = (state != IDLE);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state       <= IDLE;
			out_row     <= '0;
			out_col     <= '0;
			ker_row     <= '0;
			ker_col     <= '0;
			ker_cnt     <= '0;
			acc_valid   <= 1'b0;
			save_enable <= 1'b0;
		end
		else
		begin
			acc_valid   <= rd.read_signal;
			save_enable <= (state == ACCUM);
			case (state)
				IDLE:
				begin
					out_row <= '0;
					out_col <= '0;
					if (start)
						state <= FETCH;
				end
				FETCH:
				begin
					if (ker_cnt == ker_idx_t'(`KER_COUNT - 1))
					begin
						ker_cnt <= '0;
						ker_row <= '0;
						ker_col <= '0;
						state   <= ACCUM;
					end
					else
					begin
						ker_cnt <= ker_cnt + 4'd1;
						if (ker_col == 2'(`KER_DIM - 1))
						begin
							ker_col <= '0;
							ker_row <= ker_row + 2'd1;
						end
						else
							ker_col <= ker_col + 2'd1;
					end
				end
				// last product lands here
				ACCUM:
					state <= SAVE;
				SAVE:
				begin
					if (out_col == 3'(`OUT_DIM - 1))
					begin
						out_col <= '0;
						out_row <= out_row + 3'd1;
						state   <= (out_row == 3'(`OUT_DIM - 1)) ? DONE : FETCH;
					end
					else
					begin
						out_col <= out_col + 3'd1;
						state   <= FETCH;
					end
				end
				DONE:
					state <= IDLE;
				default:
					state <= IDLE;
			endcase
		end
	end

	// accumulator trails the reads by one cycle
	always_ff @(posedge clk)
	begin
		if (state == ACCUM)
		begin
			acc        <= '0;
			save_data  <= relu_sat(final_sum);
			save_index <= out_idx_t'(out_row * `OUT_DIM + out_col);
		end
		else if (state == IDLE)
			acc <= '0;
		else if (acc_valid)
			acc <= acc + product;
	end

	a_save_state: assert property (@(posedge clk) disable iff (rst)
		save_enable |-> state == SAVE);

endmodule

// ==== local_store.sv ====
`include "cnn_config.svh"
`timescale 1ns/10ps

module local_store import cnn_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       write_signal,
	input  logic [1:0] write_target,
	input  pix_idx_t   write_index,
	input  pixel_t     write_data,
	local_read_if.store rd
);

	pixel_t  pixel_mem [`PIX_COUNT];
	weight_t weight_mem [`KER_COUNT];
	bias_t   bias_reg;

	always_ff @(posedge clk)
	begin
		if (write_signal)
		begin
			case (write_target)
				`TGT_PIXEL:
				begin
					if (write_index < pix_idx_t'(`PIX_COUNT))
						pixel_mem[write_index] <= write_data;
				end
				`TGT_WEIGHT:
				begin
					if (write_index < pix_idx_t'(`KER_COUNT))
						weight_mem[write_index[`KER_IDX_W-1:0]] <= weight_t'(write_data);
				end
				`TGT_BIAS:
					bias_reg <= bias_t'(write_data);
				default:
					bias_reg <= bias_reg;
			endcase
		end
	end

	// registered read, pixel and weight fetched together
	always_ff @(posedge clk)
	begin
		if (rd.read_signal)
		begin
			rd.pixel_data  <= pixel_mem[rd.pix_addr];
			rd.weight_data <= weight_mem[rd.ker_addr];
		end
	end

	assign rd.bias_data = bias_reg;

	a_pixel_index: assert property (@(posedge clk) disable iff (rst)
		(write_signal && write_target == `TGT_PIXEL) |-> write_index < pix_idx_t'(`PIX_COUNT));

endmodule

// ==== bus_write_decoder.sv ====
`include "cnn_config.svh"
`timescale 1ns/10ps

module bus_write_decoder import cnn_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  bus_word_t awaddr,
	input  logic      awvalid,
	input  bus_word_t wdata,
	input  logic      wvalid,
	output logic      write_signal,
	output logic [1:0] write_target,
	output pix_idx_t  write_index,
	output pixel_t    write_data,
	output logic      start,
	output logic      irq_clear,
	output logic      pixel_done,
	output logic      weight_done,
	output logic      bias_done,
	input  logic      busy
);

	logic wr_fire;
	logic pixel_hit;
	logic weight_hit;
	logic bias_hit;
	logic start_hit;
	logic clear_hit;

	assign wr_fire    = awvalid && wvalid;
	assign pixel_hit  = wr_fire && ((awaddr & `WR_PAGE_MASK) == `PIXEL_BASE);
	assign weight_hit = wr_fire && ((awaddr & `WR_PAGE_MASK) == `WEIGHT_BASE);
	assign bias_hit   = wr_fire && ((awaddr & `WR_PAGE_MASK) == `BIAS_ADDR);
	assign start_hit  = wr_fire && ((awaddr & `WR_PAGE_MASK) == `START_ADDR);
	assign clear_hit  = wr_fire && ((awaddr & `WR_PAGE_MASK) == `IRQ_CLEAR_ADDR);

	assign write_signal = pixel_hit || weight_hit || bias_hit;
	assign write_index  = awaddr[7:2];
	assign write_data   = pixel_t'(wdata[`DATA_W-1:0]);
	assign irq_clear    = clear_hit;

	always_comb
	begin
		if (weight_hit)
			write_target = `TGT_WEIGHT;
		else if (bias_hit)
			write_target = `TGT_BIAS;
		else
			write_target = `TGT_PIXEL;
	end

	// only launch once every store is loaded and the layer is idle
	assign start = start_hit && wdata[0] && pixel_done && weight_done && bias_done && !busy;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pixel_done  <= 1'b0;
			weight_done <= 1'b0;
			bias_done   <= 1'b0;
		end
		else
		begin
			if (pixel_hit && write_index == pix_idx_t'(`PIX_COUNT - 1))
				pixel_done <= 1'b1;
			if (weight_hit && write_index == pix_idx_t'(`KER_COUNT - 1))
				weight_done <= 1'b1;
			if (bias_hit)
				bias_done <= 1'b1;
		end
	end

	// layer must pick up every start on the next edge
	a_start_idle: assert property (@(posedge clk) disable iff (rst)
		start |-> !busy ##1 busy);

endmodule

// ==== local_read_if.sv ====
`timescale 1ns/10ps

// read port of the local stores, data one cycle after read_signal
interface local_read_if import cnn_pkg::*; ();

	logic     read_signal;
	pix_idx_t pix_addr;
	ker_idx_t ker_addr;
	pixel_t   pixel_data;
	weight_t  weight_data;
	bias_t    bias_data;

	modport layer (
		output read_signal, pix_addr, ker_addr,
		input  pixel_data, weight_data, bias_data
	);

	modport store (
		input  read_signal, pix_addr, ker_addr,
		output pixel_data, weight_data, bias_data
	);

endinterface

// ==== cnn_pkg.sv ====
`include "cnn_config.svh"

package cnn_pkg;

	// sample, coefficient and bias words
	typedef logic signed [`DATA_W-1:0] pixel_t;
	typedef logic signed [`DATA_W-1:0] weight_t;
	typedef logic signed [`DATA_W-1:0] bias_t;

	// wide enough for nine full-scale products plus bias
	typedef logic signed [`ACC_W-1:0] acc_t;

	// after relu and saturation
	typedef logic [`DATA_W-1:0] result_t;

	typedef logic [`PIX_IDX_W-1:0] pix_idx_t;
	typedef logic [`KER_IDX_W-1:0] ker_idx_t;
	typedef logic [`OUT_IDX_W-1:0] out_idx_t;

	typedef logic [`BUS_W-1:0] bus_word_t;

	typedef enum logic [2:0] {IDLE, FETCH, ACCUM, SAVE, DONE} conv_state_t;

endpackage

// ==== cnn_config.svh ====
`ifndef CNN_CONFIG_SVH
`define CNN_CONFIG_SVH

// image and kernel geometry
`define IMG_DIM 6
`define KER_DIM 3
`define OUT_DIM 4
`define PIX_COUNT 36
`define KER_COUNT 9
`define OUT_COUNT 16

// widths
`define DATA_W 16
`define ACC_W 36
`define BUS_W 32
`define PIX_IDX_W 6
`define KER_IDX_W 4
`define OUT_IDX_W 4
`define SAT_MAX 32767

// store select on the local write port
`define TGT_PIXEL 2'd0
`define TGT_WEIGHT 2'd1
`define TGT_BIAS 2'd2

// host write map, word index in bits 7:2
`define WR_PAGE_MASK 32'hffff_ff00
`define PIXEL_BASE 32'h1000_0000
`define WEIGHT_BASE 32'h2000_0000
`define BIAS_ADDR 32'h3000_0000
`define START_ADDR 32'h4000_0000
`define IRQ_CLEAR_ADDR 32'h5000_0000

// host read map
`define RD_RESULT_MASK 32'hffff_ffc0
`define RESULT_BASE 32'hd000_0000
`define STATUS_ADDR 32'hd000_1000

`endif
